/* build.f */
rtl/p2p_pkg.sv
rtl/p2p_regs.sv
rtl/p2p_lane.sv
rtl/p2p_top.sv
dv/tb_p2p_sva.sv
dv/tb_p2p.sv

/* run.sh */
#!/bin/sh
# compile and run the p2p testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_p2p -f build.f -o tb_p2p

status=0
out=$(./obj_dir/tb_p2p 2>&1) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Verification passed'; then
   exit 0
fi

echo "run.sh: simulation did not report a pass (exit status $status)" >&2
exit 1

/* dv/tb_p2p.sv */
module tb_p2p
   import p2p_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   typedef logic [DATA_W+KEEP_W+1+ID_W+DEST_IN_W+USER_W-1:0]  in_beat_t;
   typedef logic [DATA_W+KEEP_W+1+ID_W+DEST_OUT_W+USER_W-1:0] out_beat_t;
   typedef enum {OP_WR, OP_RD, OP_LATCH, OP_BURST, OP_PAUSE, OP_READY} op_e;

   logic core_clk;
   logic rst_n;
   logic [TS_W-1:0] ts_cnt;
   logic reg_wr;
   logic reg_rd;
   logic [REG_ADDR_W-1:0] reg_addr;
   logic [REG_DATA_W-1:0] reg_wdata;
   logic [REG_DATA_W-1:0] reg_rdata;
   logic reg_rvalid;

   // per-lane pins indexed by lane number
   logic in_valid [2];
   logic [DATA_W-1:0] in_data [2];
   logic [KEEP_W-1:0] in_keep [2];
   logic in_last [2];
   logic [ID_W-1:0] in_id [2];
   logic [DEST_IN_W-1:0] in_dest [2];
   logic [USER_W-1:0] in_user [2];
   logic in_ready [2];
   logic out_valid [2];
   logic [DATA_W-1:0] out_data [2];
   logic [KEEP_W-1:0] out_keep [2];
   logic out_last [2];
   logic [ID_W-1:0] out_id [2];
   logic [DEST_OUT_W-1:0] out_dest [2];
   logic [USER_W-1:0] out_user [2];
   logic out_ready [2];

   // table and model state
   string row_name [$];
   op_e row_op [$];
   logic [31:0] row_a [$];
   logic [31:0] row_b [$];
   logic [1:0] row_c [$];
   string cur_name;
   in_beat_t send_q [2][$];
   out_beat_t exp_q [2][$];
   logic [1:0] rdy_mode [2];
   logic [1023:0] rdy_bits [2];
   logic [9:0] rdy_idx;
   logic pause_model;
   int cycles;
   int cycle_limit;

   p2p_top dut_i (
      .core_clk   (core_clk),
      .rst_n      (rst_n),
      .timestamp  (ts_cnt),
      .reg_wr     (reg_wr),
      .reg_rd     (reg_rd),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_rdata  (reg_rdata),
      .reg_rvalid (reg_rvalid),
      .from_sw0_valid (in_valid[0]), .from_sw0_data  (in_data[0]),
      .from_sw0_keep  (in_keep[0]),  .from_sw0_last  (in_last[0]),
      .from_sw0_id    (in_id[0]),    .from_sw0_dest  (in_dest[0]),
      .from_sw0_user  (in_user[0]),  .from_sw0_ready (in_ready[0]),
      .to_sw0_valid   (out_valid[0]), .to_sw0_data   (out_data[0]),
      .to_sw0_keep    (out_keep[0]),  .to_sw0_last   (out_last[0]),
      .to_sw0_id      (out_id[0]),    .to_sw0_dest   (out_dest[0]),
      .to_sw0_user    (out_user[0]),  .to_sw0_ready  (out_ready[0]),
      .from_sw1_valid (in_valid[1]), .from_sw1_data  (in_data[1]),
      .from_sw1_keep  (in_keep[1]),  .from_sw1_last  (in_last[1]),
      .from_sw1_id    (in_id[1]),    .from_sw1_dest  (in_dest[1]),
      .from_sw1_user  (in_user[1]),  .from_sw1_ready (in_ready[1]),
      .to_sw1_valid   (out_valid[1]), .to_sw1_data   (out_data[1]),
      .to_sw1_keep    (out_keep[1]),  .to_sw1_last   (out_last[1]),
      .to_sw1_id      (out_id[1]),    .to_sw1_dest   (out_dest[1]),
      .to_sw1_user    (out_user[1]),  .to_sw1_ready  (out_ready[1])
   );

   always #20 core_clk = ~core_clk;

   // free-running timestamp source
   always @(posedge core_clk) begin
      ts_cnt <= ts_cnt + 1'b1;
   end

   always @(posedge core_clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("Error: run passed %0d cycles before the test table finished", cycle_limit);
         $display("Verification failed");
         $fatal(1, "timeout");
      end
   end

   task automatic check_value(input string what, input logic [127:0] expected,
                              input logic [127:0] actual);
      if (actual !== expected) begin
         $display("Fail %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
         $display("Verification failed");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   // --------------------------------------------------
   // lane model, input driver and ready driver
   // --------------------------------------------------
   always @(posedge core_clk) begin : lanes
      out_beat_t act_beat;
      out_beat_t exp_beat;
      in_beat_t  beat;
      logic      paused;
      if (rst_n) begin
         for (int l = 0; l < 2; l++) begin
            paused = (l == 0) && pause_model;
            // queue depth stands in for lane occupancy
            check_value($sformatf("from_sw%0d_ready", l),
                        128'((exp_q[l].size() < 2) && !paused), 128'(in_ready[l]));
            check_value($sformatf("to_sw%0d_valid", l),
                        128'((exp_q[l].size() != 0) && !paused), 128'(out_valid[l]));
            if (out_valid[l] && out_ready[l]) begin
               act_beat = {out_data[l], out_keep[l], out_last[l], out_id[l],
                           out_dest[l], out_user[l]};
               exp_beat = exp_q[l].pop_front();
               check_value($sformatf("beat%0d", l), 128'(exp_beat), 128'(act_beat));
            end
            if (in_valid[l] && in_ready[l]) begin
               exp_q[l].push_back({in_data[l], in_keep[l], in_last[l], in_id[l],
                                   DEST_OUT_W'(in_dest[l]), in_user[l]});
            end
            // offered beat holds until taken
            if (!in_valid[l] || in_ready[l]) begin
               if (send_q[l].size() != 0) begin
                  beat = send_q[l].pop_front();
                  {in_data[l], in_keep[l], in_last[l], in_id[l], in_dest[l], in_user[l]}
                     <= beat;
                  in_valid[l] <= 1'b1;
               end else begin
                  in_valid[l] <= 1'b0;
               end
            end
            case (rdy_mode[l])
               2'd0:    out_ready[l] <= 1'b0;
               2'd1:    out_ready[l] <= 1'b1;
               default: out_ready[l] <= rdy_bits[l][rdy_idx];
            endcase
         end
         if (reg_wr && reg_addr == ADDR_CTRL) begin
            pause_model = reg_wdata[0];
         end
         rdy_idx = rdy_idx + 1'b1;
      end
   end

   // --------------------------------------------------
   // register port and table operations
   // --------------------------------------------------
   task automatic reg_write(input logic [REG_ADDR_W-1:0] addr,
                            input logic [REG_DATA_W-1:0] data);
      @(posedge core_clk);
      reg_wr <= 1'b1;
      reg_addr <= addr;
      reg_wdata <= data;
      @(posedge core_clk);
      reg_wr <= 1'b0;
   endtask

   task automatic reg_read(input logic [REG_ADDR_W-1:0] addr,
                           input logic [REG_DATA_W-1:0] exp_data);
      @(posedge core_clk);
      reg_rd <= 1'b1;
      reg_addr <= addr;
      @(posedge core_clk);
      check_value("rvalid_early", 128'(0), 128'(reg_rvalid));
      reg_rd <= 1'b0;
      @(posedge core_clk);
      check_value("rvalid", 128'(1), 128'(reg_rvalid));
      check_value("rdata", 128'(exp_data), 128'(reg_rdata));
   endtask

   task automatic latch_and_check();
      ts_word_u ts_exp;
      @(posedge core_clk);
      reg_wr <= 1'b1;
      reg_addr <= ADDR_TS_LATCH;
      reg_wdata <= $urandom;
      @(posedge core_clk);
      // counter value seen by the trigger edge
      ts_exp.whole = ts_cnt;
      reg_wr <= 1'b0;
      reg_read(ADDR_TS_LOWER, ts_exp.half.lower);
      reg_read(ADDR_TS_UPPER, ts_exp.half.upper);
   endtask

   // wait_mode picks return at once (0), after acceptance (1) or after output (2)
   task automatic run_burst(input logic [1:0] mask, input int unsigned count,
                            input logic [1:0] wait_mode);
      in_beat_t beat;
      logic     busy;
      @(negedge core_clk);
      for (int l = 0; l < 2; l++) begin
         for (int unsigned n = 0; n < count && mask[l]; n++) begin
            beat = {DATA_W'({$urandom, $urandom}), KEEP_W'($urandom), n == count - 1,
                    ID_W'(n), DEST_IN_W'($urandom), USER_W'($urandom)};
            send_q[l].push_back(beat);
         end
      end
      busy = (wait_mode != 2'd0);
      while (busy) begin
         @(negedge core_clk);
         busy = 1'b0;
         for (int l = 0; l < 2; l++) begin
            if (mask[l] && (send_q[l].size() != 0 || in_valid[l] ||
                            (wait_mode == 2'd2 && exp_q[l].size() != 0))) begin
               busy = 1'b1;
            end
         end
      end
   endtask

   task automatic set_ready(input logic [1:0] mask, input logic [1:0] mode);
      @(negedge core_clk);
      for (int l = 0; l < 2; l++) begin
         if (mask[l]) begin
            rdy_mode[l] = mode;
         end
      end
   endtask

   task automatic add_row(input string name, input op_e op, input logic [31:0] a,
                          input logic [31:0] b, input logic [1:0] c);
      row_name.push_back(name);
      row_op.push_back(op);
      row_a.push_back(a);
      row_b.push_back(b);
      row_c.push_back(c);
   endtask

   // a holds the lane mask and b the beat count or ready mode
   task automatic build_table();
      add_row("id_read",      OP_RD,    32'(ADDR_ID),      32'h5032_5030, 2'd0);
      add_row("ctrl_reset",   OP_RD,    32'(ADDR_CTRL),    0,             2'd0);
      add_row("scratch_wr",   OP_WR,    32'(ADDR_SCRATCH), 32'hA5C3_0F96, 2'd0);
      add_row("scratch_rd",   OP_RD,    32'(ADDR_SCRATCH), 32'hA5C3_0F96, 2'd0);
      add_row("ts_latch",     OP_LATCH, 0,                 0,             2'd0);
      add_row("latch_done",   OP_RD,    32'(ADDR_CTRL),    2,             2'd0);
      add_row("single_beat",  OP_BURST, 3,                 1,             2'd2);
      add_row("burst_both",   OP_BURST, 3,                 12,            2'd2);
      add_row("hold_lane0",   OP_READY, 1,                 0,             2'd0);
      add_row("fill_lane0",   OP_BURST, 1,                 2,             2'd1);
      add_row("pause_set",    OP_PAUSE, 0,                 1,             2'd0);
      add_row("pause_rd",     OP_RD,    32'(ADDR_CTRL),    3,             2'd0);
      add_row("release_out",  OP_READY, 1,                 1,             2'd0);
      add_row("offer_paused", OP_BURST, 1,                 3,             2'd0);
      add_row("lane1_flows",  OP_BURST, 2,                 8,             2'd2);
      add_row("pause_clear",  OP_PAUSE, 0,                 0,             2'd0);
      add_row("drain_lane0",  OP_BURST, 1,                 0,             2'd2);
      add_row("random_ready", OP_READY, 3,                 2,             2'd0);
      add_row("random_burst", OP_BURST, 3,                 24,            2'd2);
      add_row("ready_high",   OP_READY, 3,                 1,             2'd0);
   endtask

   initial begin
      void'($urandom(32'h385));
      core_clk = 1'b0;
      rst_n = 1'b0;
      ts_cnt = {$urandom, $urandom};
      reg_wr = 1'b0;
      reg_rd = 1'b0;
      reg_addr = '0;
      reg_wdata = '0;
      for (int l = 0; l < 2; l++) begin
         in_valid[l] = 1'b0;
         {in_data[l], in_keep[l], in_last[l], in_id[l], in_dest[l], in_user[l]} = '0;
         out_ready[l] = 1'b1;
         rdy_mode[l] = 2'd1;
         for (int i = 0; i < 32; i++) begin
            rdy_bits[l][i*32 +: 32] = $urandom;
         end
      end
      rdy_idx = '0;
      pause_model = 1'b0;
      cycles = 0;
      cur_name = "reset";
      build_table();
      cycle_limit = row_op.size() * 64 + 100;

      repeat (3) @(posedge core_clk);
      rst_n <= 1'b1;

      foreach (row_op[i]) begin
         cur_name = row_name[i];
         case (row_op[i])
            OP_WR:    reg_write(REG_ADDR_W'(row_a[i]), row_b[i]);
            OP_RD:    reg_read(REG_ADDR_W'(row_a[i]), row_b[i]);
            OP_LATCH: latch_and_check();
            OP_BURST: run_burst(row_a[i][1:0], row_b[i], row_c[i]);
            OP_PAUSE: reg_write(ADDR_CTRL, row_b[i]);
            default:  set_ready(row_a[i][1:0], row_b[i][1:0]);
         endcase
      end

      @(negedge core_clk);
      cur_name = "final";
      check_value("lane0_left", 128'(0), 128'(exp_q[0].size() + send_q[0].size()));
      check_value("lane1_left", 128'(0), 128'(exp_q[1].size() + send_q[1].size()));
      $display("Verification passed");
      $finish;
   end

endmodule

/* dv/tb_p2p_sva.sv */
module tb_p2p_sva
   import p2p_pkg::*;
#(
   parameter bit PAUSABLE = 1'b0
) (
   input logic                  core_clk,
   input logic                  rst_n,
   input logic                  tpause,
   input logic                  from_sw_ready,
   input logic                  to_sw_valid,
   input logic                  to_sw_ready,
   input logic [DATA_W-1:0]     to_sw_data,
   input logic [KEEP_W-1:0]     to_sw_keep,
   input logic                  to_sw_last,
   input logic [ID_W-1:0]       to_sw_id,
   input logic [DEST_OUT_W-1:0] to_sw_dest,
   input logic [USER_W-1:0]     to_sw_user
);
   timeunit 1ns;
   timeprecision 1ps;

   // stalled beat keeps its payload until taken
   hold_stable: assert property (@(posedge core_clk) disable iff (!rst_n)
      to_sw_valid && !to_sw_ready |=>
         $stable({to_sw_data, to_sw_keep, to_sw_last, to_sw_id, to_sw_dest, to_sw_user}))
      else $error("lane output payload changed while the beat was stalled");

   // paused lane neither accepts nor offers
   pause_blocks: assert property (@(posedge core_clk) disable iff (!rst_n)
      PAUSABLE && tpause |-> !to_sw_valid && !from_sw_ready)
      else $error("pausable lane handshake active during pause");

   // widened dest carries zeros on top
   dest_upper_zero: assert property (@(posedge core_clk) disable iff (!rst_n)
      to_sw_valid |-> to_sw_dest[DEST_OUT_W-1:DEST_IN_W] == '0)
      else $error("upper dest bits not zero on a valid beat");

endmodule

bind p2p_lane tb_p2p_sva #(.PAUSABLE(PAUSABLE)) sva_i (
   .core_clk      (core_clk),
   .rst_n         (rst_n),
   .tpause        (tpause),
   .from_sw_ready (from_sw_ready),
   .to_sw_valid   (to_sw_valid),
   .to_sw_ready   (to_sw_ready),
   .to_sw_data    (to_sw_data),
   .to_sw_keep    (to_sw_keep),
   .to_sw_last    (to_sw_last),
   .to_sw_id      (to_sw_id),
   .to_sw_dest    (to_sw_dest),
   .to_sw_user    (to_sw_user)
);

/* rtl/p2p_top.sv */
module p2p_top
   import p2p_pkg::*;
(
   input  logic                  core_clk,
   input  logic                  rst_n,
   input  logic [TS_W-1:0]       timestamp,

   // register port
   input  logic                  reg_wr,
   input  logic                  reg_rd,
   input  logic [REG_ADDR_W-1:0] reg_addr,
   input  logic [REG_DATA_W-1:0] reg_wdata,
   output logic [REG_DATA_W-1:0] reg_rdata,
   output logic                  reg_rvalid,

   // lane 0
   input  logic                  from_sw0_valid,
   input  logic [DATA_W-1:0]     from_sw0_data,
   input  logic [KEEP_W-1:0]     from_sw0_keep,
   input  logic                  from_sw0_last,
   input  logic [ID_W-1:0]       from_sw0_id,
   input  logic [DEST_IN_W-1:0]  from_sw0_dest,
   input  logic [USER_W-1:0]     from_sw0_user,
   output logic                  from_sw0_ready,

   output logic                  to_sw0_valid,
   output logic [DATA_W-1:0]     to_sw0_data,
   output logic [KEEP_W-1:0]     to_sw0_keep,
   output logic                  to_sw0_last,
   output logic [ID_W-1:0]       to_sw0_id,
   output logic [DEST_OUT_W-1:0] to_sw0_dest,
   output logic [USER_W-1:0]     to_sw0_user,
   input  logic                  to_sw0_ready,

   // lane 1
   input  logic                  from_sw1_valid,
   input  logic [DATA_W-1:0]     from_sw1_data,
   input  logic [KEEP_W-1:0]     from_sw1_keep,
   input  logic                  from_sw1_last,
   input  logic [ID_W-1:0]       from_sw1_id,
   input  logic [DEST_IN_W-1:0]  from_sw1_dest,
   input  logic [USER_W-1:0]     from_sw1_user,
   output logic                  from_sw1_ready,

   output logic                  to_sw1_valid,
   output logic [DATA_W-1:0]     to_sw1_data,
   output logic [KEEP_W-1:0]     to_sw1_keep,
   output logic                  to_sw1_last,
   output logic [ID_W-1:0]       to_sw1_id,
   output logic [DEST_OUT_W-1:0] to_sw1_dest,
   output logic [USER_W-1:0]     to_sw1_user,
   input  logic                  to_sw1_ready
);

   logic tpause;

   // --------------------------------------------------
   // register block
   // --------------------------------------------------
   p2p_regs regs_i (
      .core_clk   (core_clk),
      .rst_n      (rst_n),
      .reg_wr     (reg_wr),
      .reg_rd     (reg_rd),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_rdata  (reg_rdata),
      .reg_rvalid (reg_rvalid),
      .timestamp  (timestamp),
      .tpause     (tpause)
   );

   // --------------------------------------------------
   // stream lanes
   // --------------------------------------------------
   // lane 0 honours pause
   p2p_lane #(
      .PAUSABLE (1'b1)
   ) lane0_i (
      .core_clk      (core_clk),
      .rst_n         (rst_n),
      .tpause        (tpause),
      .from_sw_valid (from_sw0_valid),
      .from_sw_data  (from_sw0_data),
      .from_sw_keep  (from_sw0_keep),
      .from_sw_last  (from_sw0_last),
      .from_sw_id    (from_sw0_id),
      .from_sw_dest  (from_sw0_dest),
      .from_sw_user  (from_sw0_user),
      .from_sw_ready (from_sw0_ready),
      .to_sw_valid   (to_sw0_valid),
      .to_sw_data    (to_sw0_data),
      .to_sw_keep    (to_sw0_keep),
      .to_sw_last    (to_sw0_last),
      .to_sw_id      (to_sw0_id),
      .to_sw_dest    (to_sw0_dest),
      .to_sw_user    (to_sw0_user),
      .to_sw_ready   (to_sw0_ready)
   );

   // lane 1 always flows
   p2p_lane #(
      .PAUSABLE (1'b0)
   ) lane1_i (
      .core_clk      (core_clk),
      .rst_n         (rst_n),
      .tpause        (),
      .from_sw_valid (from_sw1_valid),
      .from_sw_data  (from_sw1_data),
      .from_sw_keep  (from_sw1_keep),
      .from_sw_last  (from_sw1_last),
      .from_sw_id    (from_sw1_id),
      .from_sw_dest  (from_sw1_dest),
      .from_sw_user  (from_sw1_user),
      .from_sw_ready (from_sw1_ready),
      .to_sw_valid   (to_sw1_valid),
      .to_sw_data    (to_sw1_data),
      .to_sw_keep    (to_sw1_keep),
      .to_sw_last    (to_sw1_last),
      .to_sw_id      (to_sw1_id),
      .to_sw_dest    (to_sw1_dest),
      .to_sw_user    (to_sw1_user),
      .to_sw_ready   (to_sw1_ready)
   );

endmodule

/* rtl/p2p_lane.sv */
module p2p_lane
   import p2p_pkg::*;
#(
   parameter bit PAUSABLE = 1'b0
) (
   input  logic                  core_clk,
   input  logic                  rst_n,
   input  logic                  tpause,

   // beats arriving from the switch
   input  logic                  from_sw_valid,
   input  logic [DATA_W-1:0]     from_sw_data,
   input  logic [KEEP_W-1:0]     from_sw_keep,
   input  logic                  from_sw_last,
   input  logic [ID_W-1:0]       from_sw_id,
   input  logic [DEST_IN_W-1:0]  from_sw_dest,
   input  logic [USER_W-1:0]     from_sw_user,
   output logic                  from_sw_ready,

   // beats returned to the switch
   output logic                  to_sw_valid,
   output logic [DATA_W-1:0]     to_sw_data,
   output logic [KEEP_W-1:0]     to_sw_keep,
   output logic                  to_sw_last,
   output logic [ID_W-1:0]       to_sw_id,
   output logic [DEST_OUT_W-1:0] to_sw_dest,
   output logic [USER_W-1:0]     to_sw_user,
   input  logic                  to_sw_ready
);

   // beat storage
   logic [DATA_W-1:0]    data_mem [LANE_DEPTH];
   logic [KEEP_W-1:0]    keep_mem [LANE_DEPTH];
   logic                 last_mem [LANE_DEPTH];
   logic [ID_W-1:0]      id_mem   [LANE_DEPTH];
   logic [DEST_IN_W-1:0] dest_mem [LANE_DEPTH];
   logic [USER_W-1:0]    user_mem [LANE_DEPTH];

   logic [LANE_PTR_W-1:0] wr_ptr;
   logic [LANE_PTR_W-1:0] rd_ptr;
   logic [LANE_CNT_W-1:0] count;

   logic paused;
   logic full;
   logic empty;
   logic push;
   logic pop;

   // --------------------------------------------------
   // handshake
   // --------------------------------------------------
   // tpause is ignored on a lane built without pause
   assign paused = PAUSABLE && tpause;

   assign full  = (count == LANE_CNT_W'(LANE_DEPTH));
   assign empty = (count == '0);

   // ready depends on registered state only
   assign from_sw_ready = !full && !paused;
   assign to_sw_valid   = !empty && !paused;

   assign push = from_sw_valid && from_sw_ready;
   assign pop  = to_sw_valid && to_sw_ready;

   // --------------------------------------------------
   // pointers and occupancy
   // --------------------------------------------------
   always_ff @(posedge core_clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // --------------------------------------------------
   // storage
   // --------------------------------------------------
   always_ff @(posedge core_clk) begin
      if (push) begin
         data_mem[wr_ptr] <= from_sw_data;
         keep_mem[wr_ptr] <= from_sw_keep;
         last_mem[wr_ptr] <= from_sw_last;
         id_mem[wr_ptr]   <= from_sw_id;
         dest_mem[wr_ptr] <= from_sw_dest;
         user_mem[wr_ptr] <= from_sw_user;
      end
   end

   // head of buffer drives the output
   assign to_sw_data = data_mem[rd_ptr];
   assign to_sw_keep = keep_mem[rd_ptr];
   assign to_sw_last = last_mem[rd_ptr];
   assign to_sw_id   = id_mem[rd_ptr];
   assign to_sw_user = user_mem[rd_ptr];

   // narrow switch dest widened with zeros
   assign to_sw_dest = {{(DEST_OUT_W-DEST_IN_W){1'b0}}, dest_mem[rd_ptr]};

endmodule

/* rtl/p2p_regs.sv */
module p2p_regs
   import p2p_pkg::*;
(
   input  logic                  core_clk,
   input  logic                  rst_n,

   input  logic                  reg_wr,
   input  logic                  reg_rd,
   input  logic [REG_ADDR_W-1:0] reg_addr,
   input  logic [REG_DATA_W-1:0] reg_wdata,
   output logic [REG_DATA_W-1:0] reg_rdata,
   output logic                  reg_rvalid,

   input  logic [TS_W-1:0]       timestamp,
   output logic                  tpause
);

   logic                  pause_q;
   logic                  latch_done_q;
   logic [REG_DATA_W-1:0] scratch_q;

   logic                  wr_ctrl;
   logic                  wr_latch;
   logic                  wr_scratch;

   logic [TS_W-1:0]       ts_capture;
   logic                  latch_evt_d1;
   ts_word_u              ts_status;

   logic [REG_DATA_W-1:0] rd_word;

   // --------------------------------------------------
   // write decode
   // --------------------------------------------------
   assign wr_ctrl    = reg_wr && (reg_addr == ADDR_CTRL);
   assign wr_latch   = reg_wr && (reg_addr == ADDR_TS_LATCH);
   assign wr_scratch = reg_wr && (reg_addr == ADDR_SCRATCH);

   // control and scratch
   always_ff @(posedge core_clk or negedge rst_n) begin
      if (!rst_n) begin
         pause_q   <= 1'b0;
         scratch_q <= '0;
      end else begin
         if (wr_ctrl) begin
            // latch_done is read-only status
            pause_q <= reg_wdata[0];
         end
         if (wr_scratch) begin
            scratch_q <= reg_wdata;
         end
      end
   end

   assign tpause = pause_q;

   // --------------------------------------------------
   // timestamp latch
   // --------------------------------------------------
   // sample the free-running counter on the trigger edge
   always_ff @(posedge core_clk) begin
      if (wr_latch) begin
         ts_capture <= timestamp;
      end
   end

   // status halves follow one cycle later
   always_ff @(posedge core_clk or negedge rst_n) begin
      if (!rst_n) begin
         latch_evt_d1 <= 1'b0;
         latch_done_q <= 1'b0;
      end else begin
         latch_evt_d1 <= wr_latch;
         if (latch_evt_d1) begin
            latch_done_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge core_clk) begin
      if (latch_evt_d1) begin
         ts_status.whole <= ts_capture;
      end
   end

   // --------------------------------------------------
   // read path
   // --------------------------------------------------
   always_comb begin
      case (reg_addr)
         ADDR_CTRL:     rd_word = {{(REG_DATA_W-2){1'b0}}, latch_done_q, pause_q};
         ADDR_TS_LOWER: rd_word = ts_status.half.lower;
         ADDR_TS_UPPER: rd_word = ts_status.half.upper;
         ADDR_SCRATCH:  rd_word = scratch_q;
         ADDR_ID:       rd_word = P2P_ID;
         // trigger register and holes read as zero
         default:       rd_word = '0;
      endcase
   end

   always_ff @(posedge core_clk or negedge rst_n) begin
      if (!rst_n) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_rd;
      end
   end

   // selected word captured on the read strobe
   always_ff @(posedge core_clk) begin
      if (reg_rd) begin
         reg_rdata <= rd_word;
      end
   end

endmodule

/* rtl/p2p_pkg.sv */
package p2p_pkg;

   // --------------------------------------------------
   // stream field widths
   // --------------------------------------------------
   localparam int DATA_W     = 64;
   localparam int KEEP_W     = 8;
   localparam int ID_W       = 4;
   localparam int USER_W     = 8;
   localparam int DEST_IN_W  = 2;
   localparam int DEST_OUT_W = 4;

   // skid buffer depth per lane
   localparam int LANE_DEPTH = 2;
   localparam int LANE_PTR_W = $clog2(LANE_DEPTH);
   localparam int LANE_CNT_W = $clog2(LANE_DEPTH + 1);

   // --------------------------------------------------
   // register port
   // --------------------------------------------------
   localparam int REG_ADDR_W = 4;
   localparam int REG_DATA_W = 32;
   localparam int TS_W       = 2 * REG_DATA_W;

   localparam logic [REG_ADDR_W-1:0] ADDR_CTRL     = 4'd0;
   localparam logic [REG_ADDR_W-1:0] ADDR_TS_LATCH = 4'd1;
   localparam logic [REG_ADDR_W-1:0] ADDR_TS_LOWER = 4'd2;
   localparam logic [REG_ADDR_W-1:0] ADDR_TS_UPPER = 4'd3;
   localparam logic [REG_ADDR_W-1:0] ADDR_SCRATCH  = 4'd4;
   localparam logic [REG_ADDR_W-1:0] ADDR_ID       = 4'd5;

   // identity word, reads as ascii "P2P0"
   localparam logic [REG_DATA_W-1:0] P2P_ID = 32'h5032_5030;

   // --------------------------------------------------
   // latched timestamp, whole or by halves
   // --------------------------------------------------
   typedef struct packed {
      logic [REG_DATA_W-1:0] upper;
      logic [REG_DATA_W-1:0] lower;
   } ts_halves_t;

   typedef union packed {
      logic [TS_W-1:0] whole;
      ts_halves_t      half;
   } ts_word_u;

endpackage
